// File: logic/pool_pkg.sv
// Shared word format, register map and widths for the 2x2 max-pooling block; import where needed.
package pool_pkg;

    // Width of one pixel or pooled word.
    localparam int POOL_W = 32;

    // Width of the row-width register and of the column counters.
    localparam int WIDTH_BITS = 16;

    // APB register offsets.
    localparam logic [3:0] ADDR_CTRL  = 4'h0; // Bit 0 enable, bit 1 float mode.
    localparam logic [3:0] ADDR_WIDTH = 4'h4; // Row width in pixels, even.
    localparam logic [3:0] ADDR_COUNT = 4'h8; // Pooled output count, read only.

    // Bit positions inside the control register.
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_FLOAT_BIT  = 1;

    // Row width after reset.
    localparam logic [WIDTH_BITS-1:0] WIDTH_RESET = 16'd2;

    // One pooling word, seen either as a signed fixed-point value or as an IEEE-754 single.
    typedef union packed {
        logic signed [POOL_W-1:0] fixed;
        struct packed {
            logic       sign;
            logic [7:0] exponent;
            logic [22:0] mantissa;
        } fp;
    } pool_word_u;

endpackage

// File: logic/pool_regs.sv
// APB register file for the pooling block: control, row width and the pooled-output counter.
`timescale 1ns/1ps

module pool_regs #(
    parameter int MAX_IMG_WIDTH = 128
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [3:0]                    paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          enable,
    output logic                          float_mode,
    output logic [pool_pkg::WIDTH_BITS-1:0] img_width,
    input  logic                          pool_valid
);
    import pool_pkg::*;

    logic        access;
    logic        wr_access;
    logic        addr_mapped;
    logic        width_legal;
    logic        wr_error;
    logic        enable_rise;
    logic [31:0] count;

    assign access    = psel & penable;
    assign wr_access = access & pwrite;

    assign addr_mapped = (paddr == ADDR_CTRL) || (paddr == ADDR_WIDTH) || (paddr == ADDR_COUNT);

    // Even, at least 2 and no larger than the line buffer.
    assign width_legal = (pwdata[0] == 1'b0) && (pwdata >= 32'd2) &&
                         (pwdata <= 32'(MAX_IMG_WIDTH));

    always_comb begin
        wr_error = 1'b0;
        if (paddr == ADDR_COUNT) begin
            wr_error = 1'b1;
        end else if (paddr == ADDR_WIDTH) begin
            wr_error = !width_legal || enable; // Width is frozen while the stream runs.
        end
    end

    assign pready  = 1'b1; // Zero wait states.
    assign pslverr = access & (!addr_mapped | (pwrite & wr_error));

    assign enable_rise = wr_access && (paddr == ADDR_CTRL) && pwdata[CTRL_ENABLE_BIT] && !enable;

    always_comb begin
        case (paddr)
            ADDR_CTRL:  prdata = {30'd0, float_mode, enable};
            ADDR_WIDTH: prdata = {{(32 - WIDTH_BITS){1'b0}}, img_width};
            ADDR_COUNT: prdata = count;
            default:    prdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable     <= 1'b0;
            float_mode <= 1'b0;
            img_width  <= WIDTH_RESET;
        end else if (wr_access && !pslverr) begin
            if (paddr == ADDR_CTRL) begin
                enable     <= pwdata[CTRL_ENABLE_BIT];
                float_mode <= pwdata[CTRL_FLOAT_BIT];
            end
            if (paddr == ADDR_WIDTH) begin
                img_width <= pwdata[WIDTH_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= 32'd0;
        end else if (enable_rise) begin
            count <= 32'd0; // A fresh run starts its own tally.
        end else if (pool_valid) begin
            count <= count + 32'd1;
        end
    end

endmodule

// File: logic/pool_line_buffer.sv
// Circular one-row pixel memory; reads the word one row above and stores the current pixel.
`timescale 1ns/1ps

module pool_line_buffer #(
    parameter int MAX_IMG_WIDTH = 128
) (
    input  logic                            clk,
    input  logic [pool_pkg::WIDTH_BITS-1:0] addr,
    input  logic                            wr_en,
    input  logic [pool_pkg::POOL_W-1:0]     wr_data,
    output logic [pool_pkg::POOL_W-1:0]     rd_data
);
    import pool_pkg::*;

    localparam int ADDR_BITS = (MAX_IMG_WIDTH > 1) ? $clog2(MAX_IMG_WIDTH) : 1;

    logic [POOL_W-1:0]    mem [MAX_IMG_WIDTH];
    logic [ADDR_BITS-1:0] index;

    // The column never exceeds the row width, so the low bits address the row.
    assign index = addr[ADDR_BITS-1:0];

    // Read before write: the old word is the pixel from the previous row.
    assign rd_data = mem[index];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index] <= wr_data;
        end
    end

endmodule

// File: logic/pool_window.sv
// Tracks row and column of the input stream and builds the 2x2 window for the max tree.
`timescale 1ns/1ps

module pool_window (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            enable,
    input  logic [pool_pkg::WIDTH_BITS-1:0] img_width,
    input  logic [pool_pkg::POOL_W-1:0]     pixel_in,
    input  logic                            pixel_valid,
    input  logic [pool_pkg::POOL_W-1:0]     lb_rd_data,
    output logic [pool_pkg::WIDTH_BITS-1:0] lb_addr,
    output logic                            lb_wr_en,
    output logic [pool_pkg::POOL_W-1:0]     lb_wr_data,
    output logic [pool_pkg::POOL_W-1:0]     win_a,
    output logic [pool_pkg::POOL_W-1:0]     win_b,
    output logic [pool_pkg::POOL_W-1:0]     win_c,
    output logic [pool_pkg::POOL_W-1:0]     win_d,
    output logic                            win_valid
);
    import pool_pkg::*;

    logic                  accept;
    logic                  last_col;
    logic                  win_done;
    logic [WIDTH_BITS-1:0] col;
    logic                  row_odd;
    logic [POOL_W-1:0]     prev_pixel;
    logic [POOL_W-1:0]     prev_above;

    assign accept   = pixel_valid & enable;
    assign last_col = (col == img_width - WIDTH_BITS'(1));

    // Bottom-right pixel of a window: odd row and odd column.
    assign win_done = accept & row_odd & col[0];

    // Each pixel lands at its column, replacing the word from the row above.
    assign lb_addr    = col;
    assign lb_wr_en   = accept;
    assign lb_wr_data = pixel_in;

    // Counters sit at row 0, column 0 while disabled, so enabling always restarts the frame.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col     <= '0;
            row_odd <= 1'b0;
        end else if (!enable) begin
            col     <= '0;
            row_odd <= 1'b0;
        end else if (accept) begin
            if (last_col) begin
                col     <= '0;
                row_odd <= ~row_odd; // Only the row parity matters.
            end else begin
                col <= col + WIDTH_BITS'(1);
            end
        end
    end

    // Left column of the window, held until the right column arrives.
    always_ff @(posedge clk) begin
        if (accept) begin
            prev_pixel <= pixel_in;
            prev_above <= lb_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (win_done) begin
            win_a <= prev_above; // Top left.
            win_b <= lb_rd_data; // Top right.
            win_c <= prev_pixel; // Bottom left.
            win_d <= pixel_in;   // Bottom right.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= win_done;
        end
    end

endmodule

// File: logic/pool_max_tree.sv
// Registered four-input maximum over fixed-point or IEEE single words, one result per window.
`timescale 1ns/1ps

module pool_max_tree (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        float_mode,
    input  logic [pool_pkg::POOL_W-1:0] win_a,
    input  logic [pool_pkg::POOL_W-1:0] win_b,
    input  logic [pool_pkg::POOL_W-1:0] win_c,
    input  logic [pool_pkg::POOL_W-1:0] win_d,
    input  logic                        win_valid,
    output logic [pool_pkg::POOL_W-1:0] pool_out,
    output logic                        pool_valid
);
    import pool_pkg::*;

    // Sign-magnitude order for singles; the two zeros count as equal.
    function automatic logic float_ge(input pool_word_u x, input pool_word_u y);
        logic [30:0] mag_x;
        logic [30:0] mag_y;
        mag_x = {x.fp.exponent, x.fp.mantissa};
        mag_y = {y.fp.exponent, y.fp.mantissa};
        if (mag_x == '0 && mag_y == '0) begin
            return 1'b1;
        end
        if (x.fp.sign != y.fp.sign) begin
            return ~x.fp.sign;
        end
        if (x.fp.sign) begin
            return mag_x <= mag_y; // Larger magnitude is smaller when negative.
        end
        return mag_x >= mag_y;
    endfunction

    function automatic pool_word_u pick_max(input pool_word_u x, input pool_word_u y,
                                            input logic use_float);
        logic x_wins;
        if (use_float) begin
            x_wins = float_ge(x, y);
        end else begin
            x_wins = (x.fixed >= y.fixed);
        end
        return x_wins ? x : y;
    endfunction

    pool_word_u max_top;
    pool_word_u max_bot;
    pool_word_u max_all;

    assign max_top = pick_max(win_a, win_b, float_mode);
    assign max_bot = pick_max(win_c, win_d, float_mode);
    assign max_all = pick_max(max_top, max_bot, float_mode);

    always_ff @(posedge clk) begin
        if (win_valid) begin
            pool_out <= max_all;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pool_valid <= 1'b0;
        end else begin
            pool_valid <= win_valid;
        end
    end

endmodule

// File: logic/maxpool_top.sv
// Top level of the streaming 2x2 stride-2 max pool with its APB control port.
`timescale 1ns/1ps

module maxpool_top #(
    parameter int MAX_IMG_WIDTH = 128
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [3:0]                  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic [pool_pkg::POOL_W-1:0] pixel_in,
    input  logic                        pixel_valid,
    output logic [pool_pkg::POOL_W-1:0] pool_out,
    output logic                        pool_valid
);
    import pool_pkg::*;

    logic                  enable;
    logic                  float_mode;
    logic [WIDTH_BITS-1:0] img_width;
    logic [WIDTH_BITS-1:0] lb_addr;
    logic                  lb_wr_en;
    logic [POOL_W-1:0]     lb_wr_data;
    logic [POOL_W-1:0]     lb_rd_data;
    logic [POOL_W-1:0]     win_a;
    logic [POOL_W-1:0]     win_b;
    logic [POOL_W-1:0]     win_c;
    logic [POOL_W-1:0]     win_d;
    logic                  win_valid;

    pool_regs #(
        .MAX_IMG_WIDTH(MAX_IMG_WIDTH)
    ) pool_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .enable     (enable),
        .float_mode (float_mode),
        .img_width  (img_width),
        .pool_valid (pool_valid)
    );

    pool_window pool_window_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .img_width   (img_width),
        .pixel_in    (pixel_in),
        .pixel_valid (pixel_valid),
        .lb_rd_data  (lb_rd_data),
        .lb_addr     (lb_addr),
        .lb_wr_en    (lb_wr_en),
        .lb_wr_data  (lb_wr_data),
        .win_a       (win_a),
        .win_b       (win_b),
        .win_c       (win_c),
        .win_d       (win_d),
        .win_valid   (win_valid)
    );

    pool_line_buffer #(
        .MAX_IMG_WIDTH(MAX_IMG_WIDTH)
    ) pool_line_buffer_i (
        .clk     (clk),
        .addr    (lb_addr),
        .wr_en   (lb_wr_en),
        .wr_data (lb_wr_data),
        .rd_data (lb_rd_data)
    );

    pool_max_tree pool_max_tree_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .float_mode (float_mode),
        .win_a      (win_a),
        .win_b      (win_b),
        .win_c      (win_c),
        .win_d      (win_d),
        .win_valid  (win_valid),
        .pool_out   (pool_out),
        .pool_valid (pool_valid)
    );

endmodule

// File: sim/maxpool_tb.sv
// Self-checking testbench for maxpool_top; compile with tb.f and run through run.sh.
`timescale 1ns/1ps

module maxpool_tb;
    import pool_pkg::*;

    localparam int MAX_IMG_WIDTH = 16;
    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int SEED          = 75;
    localparam int MAX_FRAME     = 64;
    localparam int MAX_GAP       = 3;
    localparam int TOTAL_PIXELS  = 48 + 32 + 32 + 9 + 32;
    localparam int APB_OPS       = 24;
    localparam int APB_CYCLES    = 4;
    localparam int DRAINS        = 3;
    localparam int DRAIN_LIMIT   = 8;
    localparam int DRAIN_TAIL    = 4;
    localparam int STIM_CYCLES   = RESET_CYCLES + TOTAL_PIXELS * (MAX_GAP + 1) +
                                   APB_OPS * APB_CYCLES + DRAINS * (DRAIN_LIMIT + DRAIN_TAIL);
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

    logic              clk;
    logic              rst_n;
    logic [3:0]        paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic [POOL_W-1:0] pixel_in;
    logic              pixel_valid;
    logic [POOL_W-1:0] pool_out;
    logic              pool_valid;

    pool_word_u exp_word [$];
    bit         exp_float [$];
    int         exp_edge [$];
    int         edge_count = 0;
    int         error_count = 0;
    int         check_count = 0;
    int         expected_count = 0;
    bit         tb_enabled = 1'b0;

    maxpool_top #(
        .MAX_IMG_WIDTH(MAX_IMG_WIDTH)
    ) maxpool_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .pixel_in    (pixel_in),
        .pixel_valid (pixel_valid),
        .pool_out    (pool_out),
        .pool_valid  (pool_valid)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // Ordering key: negatives below both zeros, zeros below positives.
    function automatic logic [31:0] order_key(input pool_word_u w, input bit use_float);
        logic [30:0] mag;
        mag = {w.fp.exponent, w.fp.mantissa};
        if (!use_float) begin
            return {~w.fixed[31], w.fixed[30:0]};
        end
        if (w.fp.sign && mag != 31'd0) begin
            return {1'b0, ~mag};
        end
        return {1'b1, mag};
    endfunction

    function automatic pool_word_u model_max(input pool_word_u a, input pool_word_u b,
                                             input bit use_float);
        return (order_key(a, use_float) >= order_key(b, use_float)) ? a : b;
    endfunction

    function automatic pool_word_u random_word(input bit use_float);
        pool_word_u w;
        w.fixed = $urandom;
        if (use_float) begin
            if ($urandom % 5 == 0) begin
                w.fp.exponent = 8'd0; // A zero of either sign.
                w.fp.mantissa = 23'd0;
            end else begin
                w.fp.exponent = 8'd120 + 8'($urandom % 16); // Narrow range for close values.
            end
        end
        return w;
    endfunction

    function automatic bit words_match(input pool_word_u got, input pool_word_u want,
                                       input bit use_float);
        if (use_float && {got.fp.exponent, got.fp.mantissa} == 31'd0 &&
            {want.fp.exponent, want.fp.mantissa} == 31'd0) begin
            return 1'b1;
        end
        return got.fixed == want.fixed;
    endfunction

    task automatic apb_access(input bit write, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        assert (pready == 1'b1) else begin
            $display("FAILED t=%0t pready got %0b expected 1", $time, pready);
            error_count++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input bit want_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_count++;
        assert (err == want_err) else begin
            $display("FAILED t=%0t pslverr got %0b expected %0b on write to %h",
                     $time, err, want_err, addr);
            error_count++;
        end
    endtask

    task automatic read_reg(input logic [3:0] addr, input logic [31:0] want, input bit want_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        check_count++;
        assert (err == want_err) else begin
            $display("FAILED t=%0t pslverr got %0b expected %0b on read of %h",
                     $time, err, want_err, addr);
            error_count++;
        end
        assert (want_err || rdata == want) else begin
            $display("FAILED t=%0t prdata got %h expected %h at %h", $time, rdata, want, addr);
            error_count++;
        end
    endtask

    task automatic set_ctrl(input bit en, input bit float_on);
        write_reg(ADDR_CTRL, {30'd0, float_on, en}, 1'b0);
        if (en && !tb_enabled) begin
            expected_count = 0; // The counter restarts on a rising enable.
        end
        tb_enabled = en;
    endtask

    task automatic send_frame(input int width, input int height, input bit use_float,
                              input bit gaps);
        pool_word_u frame [MAX_FRAME];
        pool_word_u best;
        int         r;
        int         c;
        int         idx;
        int         idle;
        for (r = 0; r < height; r++) begin
            for (c = 0; c < width; c++) begin
                idx        = r * width + c;
                frame[idx] = random_word(use_float);
                idle       = gaps ? int'($urandom % (MAX_GAP + 1)) : 0;
                repeat (idle) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                    pixel_valid = 1'b0;
                end
                @(posedge clk);
                #DRIVE_DELAY;
                pixel_valid = 1'b1;
                pixel_in    = frame[idx];
                if (r % 2 == 1 && c % 2 == 1) begin
                    best = model_max(frame[idx - width - 1], frame[idx - width], use_float);
                    best = model_max(best, frame[idx - 1], use_float);
                    best = model_max(best, frame[idx], use_float);
                    exp_word.push_back(best);
                    exp_float.push_back(use_float);
                    exp_edge.push_back(edge_count + 2); // Taken at the next edge, seen one later.
                    expected_count++;
                end
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        pixel_valid = 1'b0;
    endtask

    // Row 0 plus the first pixel of row 1, which completes no window.
    task automatic send_partial(input int count, input bit use_float);
        int i;
        for (i = 0; i < count; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            pixel_valid = 1'b1;
            pixel_in    = random_word(use_float);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        pixel_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_word.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        check_count++;
        assert (exp_word.size() == 0) else begin
            $display("ERROR: %0d expected pooled outputs never arrived", exp_word.size());
            error_count++;
            exp_word.delete();
            exp_float.delete();
            exp_edge.delete();
        end
        repeat (DRAIN_TAIL) @(posedge clk);
    endtask

    always @(negedge clk) begin : output_check
        pool_word_u want;
        bit         want_float;
        int         want_edge;
        if (rst_n && pool_valid) begin
            check_count++;
            assert (exp_word.size() != 0) else begin
                $display("ERROR: pool_valid high at %0t with no pooled output expected", $time);
                error_count++;
            end
            if (exp_word.size() != 0) begin
                want       = exp_word.pop_front();
                want_float = exp_float.pop_front();
                want_edge  = exp_edge.pop_front();
                assert (words_match(pool_out, want, want_float)) else begin
                    $display("FAILED t=%0t pool_out got %h expected %h", $time, pool_out, want);
                    error_count++;
                end
                assert (edge_count == want_edge) else begin
                    $display("FAILED t=%0t pool_valid edge got %0d expected %0d",
                             $time, edge_count, want_edge);
                    error_count++;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++) begin
            @(posedge clk);
        end
        $display("ERROR: timeout after %0d cycles with %0d pooled outputs still expected",
                 cycles, exp_word.size());
        $display("checks=%0d errors=%0d", check_count, error_count + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        void'($urandom(SEED));
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 4'h0;
        pwdata      = 32'd0;
        pixel_in    = '0;
        pixel_valid = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(negedge clk);
        check_count++;
        assert (pool_valid == 1'b0) else begin
            $display("FAILED t=%0t pool_valid got %0b expected 0", $time, pool_valid);
            error_count++;
        end
        read_reg(ADDR_CTRL, 32'd0, 1'b0);
        read_reg(ADDR_WIDTH, 32'd2, 1'b0);
        read_reg(ADDR_COUNT, 32'd0, 1'b0);

        write_reg(ADDR_WIDTH, 32'd8, 1'b0);
        read_reg(ADDR_WIDTH, 32'd8, 1'b0);
        write_reg(ADDR_WIDTH, 32'd7, 1'b1);
        write_reg(ADDR_WIDTH, 32'd18, 1'b1);
        read_reg(ADDR_WIDTH, 32'd8, 1'b0);
        write_reg(ADDR_COUNT, 32'd5, 1'b1);
        read_reg(4'hC, 32'd0, 1'b1);
        set_ctrl(1'b1, 1'b0);
        write_reg(ADDR_WIDTH, 32'd4, 1'b1);
        read_reg(ADDR_WIDTH, 32'd8, 1'b0);

        send_frame(8, 6, 1'b0, 1'b1);
        wait_drain();
        read_reg(ADDR_COUNT, 32'(expected_count), 1'b0);

        set_ctrl(1'b0, 1'b0);
        set_ctrl(1'b1, 1'b1);
        read_reg(ADDR_COUNT, 32'd0, 1'b0);
        send_frame(8, 4, 1'b1, 1'b1);
        send_frame(8, 4, 1'b1, 1'b1);
        wait_drain();
        read_reg(ADDR_COUNT, 32'(expected_count), 1'b0);

        // Leave the window mid-row and on an odd row before the restart.
        send_partial(9, 1'b1);
        set_ctrl(1'b0, 1'b1);
        set_ctrl(1'b1, 1'b1);
        read_reg(ADDR_COUNT, 32'd0, 1'b0);
        send_frame(8, 4, 1'b1, 1'b0);
        wait_drain();
        read_reg(ADDR_COUNT, 32'(expected_count), 1'b0);

        $display("checks=%0d errors=%0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/pool_pkg.sv
logic/pool_regs.sv
logic/pool_line_buffer.sv
logic/pool_window.sv
logic/pool_max_tree.sv
logic/maxpool_top.sv
sim/maxpool_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module maxpool_tb -o maxpool_sim \
    && ./obj_dir/maxpool_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
